//--- include/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// address split, tag | index | byte offset
`define CACHE_TAG_W 5
`define CACHE_INDEX_W 8
`define CACHE_OFFSET_W 3
`define CACHE_ADDR_W (`CACHE_TAG_W + `CACHE_INDEX_W + `CACHE_OFFSET_W)

// data word width
`define CACHE_WORD_W 16

// sets per way, words per line
`define CACHE_SETS 256
`define CACHE_LINE_WORDS 4

// cycles from memory rd strobe to data
`define MEM_RD_LATENCY 2

`endif

//--- source/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

	typedef logic [`CACHE_ADDR_W-1:0] addr_t;
	typedef logic [`CACHE_WORD_W-1:0] word_t;
	typedef logic [`CACHE_TAG_W-1:0] tag_t;
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

	// controller states, write-back then refill
	typedef enum logic [3:0] {
		idle,
		wb_0, wb_1, wb_2, wb_3,
		fill_0, fill_1, fill_2, fill_3, fill_4, fill_5
	} ctrl_state_t;

	// one way's answer for the current access
	typedef struct packed {
		logic hit;
		logic valid;
		logic dirty;
		tag_t tag;
		word_t word;
	} way_lookup_t;

	// shared access driven into both ways
	typedef struct packed {
		index_t index;
		offset_t offset;
		tag_t tag;
		word_t wdata;
		logic compare;
		logic write;
		logic valid_in;
	} way_access_t;

	typedef struct packed {
		logic rd;
		logic wr;
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic rd;
		logic wr;
		addr_t addr;
		word_t wdata;
	} sys_req_t;

endpackage

//--- source/cache_way.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_way (
	input  logic                   clk,
	input  logic                   rst,
	input  cache_pkg::way_access_t access,
	input  logic                   we,
	output cache_pkg::way_lookup_t lookup
);

	// per-set state bits, cleared on reset
	logic [`CACHE_SETS-1:0] valid_bits;
	logic [`CACHE_SETS-1:0] dirty_bits;

	// tag and line storage
	cache_pkg::tag_t tag_mem [`CACHE_SETS];
	cache_pkg::word_t data_mem [`CACHE_SETS][`CACHE_LINE_WORDS];

	// word within the line, byte offset minus bit 0
	logic [`CACHE_OFFSET_W-2:0] word_sel;
	logic wr_en;

	// lookup pieces
	logic set_valid;
	logic set_dirty;
	cache_pkg::tag_t set_tag;

	assign word_sel = access.offset[`CACHE_OFFSET_W-1:1];
	// controller flags the write, we picks the way
	assign wr_en = access.write & we;

	assign set_valid = valid_bits[access.index];
	assign set_dirty = dirty_bits[access.index];
	assign set_tag = tag_mem[access.index];

	// combinational compare, no clock in the read path
	always_comb
	begin
		lookup.hit = set_valid && (set_tag == access.tag);
		lookup.valid = set_valid;
		lookup.dirty = set_dirty;
		lookup.tag = set_tag;
		lookup.word = data_mem[access.index][word_sel];
	end

	// valid and dirty bookkeeping
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else if (wr_en)
		begin
			if (access.valid_in)
			begin
				// refill write, line is valid again
				// dirty only if a write miss merged in
				valid_bits[access.index] <= 1'b1;
				dirty_bits[access.index] <= access.compare;
			end
			else if (access.compare)
			begin
				// write hit marks the line modified
				dirty_bits[access.index] <= 1'b1;
			end
		end
	end

	// data and tag arrays
	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			data_mem[access.index][word_sel] <= access.wdata;
			// tag only changes on refill
			if (access.valid_in)
			begin
				tag_mem[access.index] <= access.tag;
			end
		end
	end

endmodule

//--- source/cache_controller.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_controller (
	input  logic                   clk,
	input  logic                   rst,
	input  cache_pkg::sys_req_t    req,
	input  cache_pkg::way_lookup_t lookup_0,
	input  cache_pkg::way_lookup_t lookup_1,
	input  cache_pkg::word_t       mem_rdata,
	output cache_pkg::way_access_t access,
	output logic                   way_we_0,
	output logic                   way_we_1,
	output cache_pkg::mem_req_t    mem_req,
	output logic                   done,
	output logic                   cache_hit,
	output logic                   stall,
	output cache_pkg::word_t       rdata
);

	cache_pkg::ctrl_state_t state_q;
	cache_pkg::ctrl_state_t state_d;

	// way chosen at miss time, request kind, round robin victim
	logic sel_way_q;
	logic is_wr_q;
	logic victim_q;
	// requested word, caught while the fill passes by
	cache_pkg::word_t rd_latch_q;

	// request fields
	cache_pkg::tag_t req_tag;
	cache_pkg::index_t req_index;
	cache_pkg::offset_t req_offset;
	logic any_req;

	// idle lookup results
	logic hit_any;
	logic pick_way;
	logic pick_dirty;
	logic start_miss;

	// sequencing controls from the FSM
	logic issue_rd;
	logic issue_wb;
	logic fill_wr;
	logic last_fill;
	cache_pkg::offset_t mem_off;
	cache_pkg::offset_t fill_off;

	cache_pkg::way_lookup_t cur_lookup;
	cache_pkg::word_t fill_word;
	logic fill_match;

	assign req_tag = req.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	assign req_index = req.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign req_offset = req.addr[`CACHE_OFFSET_W-1:0];
	assign any_req = req.rd | req.wr;

	assign hit_any = lookup_0.hit | lookup_1.hit;
	assign start_miss = (state_q == cache_pkg::idle) && any_req && !hit_any;

	// hit way, else an empty way (way 0 first), else the victim
	always_comb
	begin
		if (lookup_0.hit)
			pick_way = 1'b0;
		else if (lookup_1.hit)
			pick_way = 1'b1;
		else if (!lookup_0.valid)
			pick_way = 1'b0;
		else if (!lookup_1.valid)
			pick_way = 1'b1;
		else
			pick_way = victim_q;
	end

	assign pick_dirty = pick_way ? (lookup_1.valid & lookup_1.dirty)
		: (lookup_0.valid & lookup_0.dirty);

	// the way being evicted or refilled
	assign cur_lookup = sel_way_q ? lookup_1 : lookup_0;

	// write miss merges system data into its fill slot
	assign fill_match = fill_wr && (fill_off == req_offset);
	assign fill_word = (is_wr_q && fill_off == req_offset) ? req.wdata : mem_rdata;

	// next state and per-state sequencing
	always_comb
	begin
		state_d = state_q;
		issue_rd = 1'b0;
		issue_wb = 1'b0;
		fill_wr = 1'b0;
		last_fill = 1'b0;
		mem_off = 3'd0;
		fill_off = 3'd0;
		case (state_q)
			cache_pkg::idle:
			begin
				if (start_miss)
					state_d = pick_dirty ? cache_pkg::wb_0 : cache_pkg::fill_0;
			end
			// old line out, one word per cycle
			cache_pkg::wb_0:
			begin
				issue_wb = 1'b1;
				mem_off = 3'd0;
				state_d = cache_pkg::wb_1;
			end
			cache_pkg::wb_1:
			begin
				issue_wb = 1'b1;
				mem_off = 3'd2;
				state_d = cache_pkg::wb_2;
			end
			cache_pkg::wb_2:
			begin
				issue_wb = 1'b1;
				mem_off = 3'd4;
				state_d = cache_pkg::wb_3;
			end
			cache_pkg::wb_3:
			begin
				issue_wb = 1'b1;
				mem_off = 3'd6;
				state_d = cache_pkg::fill_0;
			end
			// reads lead the way writes by the memory latency
			cache_pkg::fill_0:
			begin
				issue_rd = 1'b1;
				mem_off = 3'd0;
				state_d = cache_pkg::fill_1;
			end
			cache_pkg::fill_1:
			begin
				issue_rd = 1'b1;
				mem_off = 3'd2;
				state_d = cache_pkg::fill_2;
			end
			cache_pkg::fill_2:
			begin
				issue_rd = 1'b1;
				mem_off = 3'd4;
				fill_wr = 1'b1;
				fill_off = 3'd0;
				state_d = cache_pkg::fill_3;
			end
			cache_pkg::fill_3:
			begin
				issue_rd = 1'b1;
				mem_off = 3'd6;
				fill_wr = 1'b1;
				fill_off = 3'd2;
				state_d = cache_pkg::fill_4;
			end
			cache_pkg::fill_4:
			begin
				fill_wr = 1'b1;
				fill_off = 3'd4;
				state_d = cache_pkg::fill_5;
			end
			cache_pkg::fill_5:
			begin
				fill_wr = 1'b1;
				fill_off = 3'd6;
				last_fill = 1'b1;
				state_d = cache_pkg::idle;
			end
			default:
			begin
				state_d = cache_pkg::idle;
			end
		endcase
	end

	// access into both ways
	always_comb
	begin
		access = '0;
		access.index = req_index;
		access.tag = req_tag;
		if (state_q == cache_pkg::idle)
		begin
			// compare lookup, write hit goes straight in
			access.offset = req_offset;
			access.wdata = req.wdata;
			access.compare = 1'b1;
			access.write = req.wr;
		end
		else if (fill_wr)
		begin
			access.offset = fill_off;
			access.wdata = fill_word;
			// last fill word marks the line dirty on a write miss
			access.compare = last_fill & is_wr_q;
			access.write = 1'b1;
			access.valid_in = 1'b1;
		end
		else
		begin
			// write-back reads the old word at the memory offset
			access.offset = mem_off;
		end
	end

	// idle writes only the hit way, fills only the chosen way
	assign way_we_0 = (state_q == cache_pkg::idle) ? (req.wr & hit_any & ~pick_way)
		: (fill_wr & ~sel_way_q);
	assign way_we_1 = (state_q == cache_pkg::idle) ? (req.wr & hit_any & pick_way)
		: (fill_wr & sel_way_q);

	// memory side, old tag for write-back, request tag for refill
	always_comb
	begin
		mem_req.rd = issue_rd;
		mem_req.wr = issue_wb;
		if (issue_wb)
			mem_req.addr = {cur_lookup.tag, req_index, mem_off};
		else
			mem_req.addr = {req_tag, req_index, mem_off};
		mem_req.wdata = cur_lookup.word;
	end

	// system side
	always_comb
	begin
		if (state_q == cache_pkg::idle)
		begin
			done = any_req & hit_any;
			cache_hit = any_req & hit_any;
			stall = any_req & ~hit_any;
			rdata = pick_way ? lookup_1.word : lookup_0.word;
		end
		else
		begin
			done = last_fill;
			cache_hit = 1'b0;
			// stall drops in the done cycle
			stall = ~last_fill;
			rdata = fill_match ? fill_word : rd_latch_q;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q <= cache_pkg::idle;
			sel_way_q <= 1'b0;
			is_wr_q <= 1'b0;
			victim_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			if (start_miss)
			begin
				sel_way_q <= pick_way;
				is_wr_q <= req.wr;
			end
			// next miss in a full set evicts the other way
			if (last_fill)
				victim_q <= ~victim_q;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_match)
			rd_latch_q <= fill_word;
	end

endmodule

//--- source/bank_memory.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module bank_memory (
	input  logic                clk,
	input  logic                rst,
	input  cache_pkg::mem_req_t req,
	output cache_pkg::word_t    rdata
);

	// bank from address bits 2:1, entry from the bits above
	localparam int BANK_W = `CACHE_OFFSET_W - 1;
	localparam int ENTRY_W = `CACHE_TAG_W + `CACHE_INDEX_W;
	localparam int ENTRIES = 1 << ENTRY_W;

	typedef struct packed {
		logic valid;
		logic [BANK_W-1:0] bank;
		logic [ENTRY_W-1:0] entry;
	} rd_stage_t;

	cache_pkg::word_t banks [`CACHE_LINE_WORDS][ENTRIES];

	// read pipeline, one slot per cycle of latency
	rd_stage_t pipe [`MEM_RD_LATENCY];

	logic [BANK_W-1:0] req_bank;
	logic [ENTRY_W-1:0] req_entry;

	assign req_bank = req.addr[`CACHE_OFFSET_W-1:1];
	assign req_entry = req.addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];

	// simulation start state, all zero
	initial
	begin
		for (int b = 0; b < `CACHE_LINE_WORDS; b++)
			for (int e = 0; e < ENTRIES; e++)
				banks[b][e] = '0;
	end

	// single cycle write
	always_ff @(posedge clk)
	begin
		if (req.wr)
			banks[req_bank][req_entry] <= req.wdata;
	end

	// shift reads toward the output
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `MEM_RD_LATENCY; i++)
				pipe[i] <= '0;
		end
		else
		begin
			pipe[0] <= {req.rd, req_bank, req_entry};
			for (int i = 1; i < `MEM_RD_LATENCY; i++)
				pipe[i] <= pipe[i-1];
		end
	end

	// last stage addresses the bank array
	assign rdata = pipe[`MEM_RD_LATENCY-1].valid
		? banks[pipe[`MEM_RD_LATENCY-1].bank][pipe[`MEM_RD_LATENCY-1].entry] : '0;

endmodule

//--- source/cache_top.sv
`timescale 1ns/1ns

module cache_top (
	input  logic                clk,
	input  logic                rst,
	input  cache_pkg::sys_req_t req,
	output logic                done,
	output logic                cache_hit,
	output logic                stall,
	output cache_pkg::word_t    rdata
);

	// shared access, per-way write enables
	cache_pkg::way_access_t access;
	logic way_we_0;
	logic way_we_1;

	// per-way lookup results
	cache_pkg::way_lookup_t lookup_0;
	cache_pkg::way_lookup_t lookup_1;

	// memory path
	cache_pkg::mem_req_t mem_req;
	cache_pkg::word_t mem_rdata;

	cache_way u_way_0 (
		.clk    (clk),
		.rst    (rst),
		.access (access),
		.we     (way_we_0),
		.lookup (lookup_0)
	);

	cache_way u_way_1 (
		.clk    (clk),
		.rst    (rst),
		.access (access),
		.we     (way_we_1),
		.lookup (lookup_1)
	);

	cache_controller u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.lookup_0  (lookup_0),
		.lookup_1  (lookup_1),
		.mem_rdata (mem_rdata),
		.access    (access),
		.way_we_0  (way_we_0),
		.way_we_1  (way_we_1),
		.mem_req   (mem_req),
		.done      (done),
		.cache_hit (cache_hit),
		.stall     (stall),
		.rdata     (rdata)
	);

	// backing store, fixed read latency
	bank_memory u_mem (
		.clk   (clk),
		.rst   (rst),
		.req   (mem_req),
		.rdata (mem_rdata)
	);

endmodule

//--- testbench/cache_assert.sv
`timescale 1ns/1ns

module cache_assert (
	input logic                clk,
	input logic                rst,
	input cache_pkg::mem_req_t mem_req,
	input logic                done,
	input logic                stall
);

	// memory sees one access kind per cycle
	property mem_one_kind;
		@(posedge clk) disable iff (rst)
		!(mem_req.rd && mem_req.wr);
	endproperty

	// done is the end of a stall, never inside it
	property done_without_stall;
		@(posedge clk) disable iff (rst)
		!(done && stall);
	endproperty

	// longest path is write-back plus refill
	property stall_ends_in_done;
		@(posedge clk) disable iff (rst)
		$rose(stall) |-> ##[1:11] done;
	endproperty

	property quiet_in_reset;
		@(posedge clk)
		rst |-> !done;
	endproperty

	assert property (mem_one_kind)
		else $error("memory rd and wr high in the same cycle");
	assert property (done_without_stall)
		else $error("done and stall high together");
	assert property (stall_ends_in_done)
		else $error("done did not follow stall within 11 cycles");
	assert property (quiet_in_reset)
		else $error("done high during reset");

endmodule

//--- testbench/cache_tb.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_tb;

	localparam int RAND_OPS = 40;
	// miss timing, refill then the extra write-back states
	localparam int FILL_CYCLES = 6;
	localparam int WB_CYCLES = 4;

	typedef struct packed {
		logic rd;
		logic wr;
		cache_pkg::addr_t addr;
		cache_pkg::word_t wdata;
		logic exp_hit;
	} op_t;

	logic clk;
	logic rst;
	cache_pkg::sys_req_t req;
	logic done;
	logic cache_hit;
	logic stall;
	cache_pkg::word_t rdata;

	op_t ops [$];
	string names [$];
	int errors;
	int checks;
	int cycles;
	int max_cycles;
	logic [31:0] seed;

	// reference two-way tag model and flat shadow memory
	logic m_valid [2][`CACHE_SETS];
	logic m_dirty [2][`CACHE_SETS];
	cache_pkg::tag_t m_tag [2][`CACHE_SETS];
	logic m_victim;
	cache_pkg::word_t shadow [1 << (`CACHE_ADDR_W - 1)];

	cache_top u_dut (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.done      (done),
		.cache_hit (cache_hit),
		.stall     (stall),
		.rdata     (rdata)
	);

	bind cache_controller cache_assert u_assert (
		.clk     (clk),
		.rst     (rst),
		.mem_req (mem_req),
		.done    (done),
		.stall   (stall)
	);

	always #50 clk = ~clk;

	// run limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("timeout after %0d cycles, done never came", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic cache_pkg::addr_t make_addr(input int tg, input int idx, input int off);
		return {tg[4:0], idx[7:0], off[2:0]};
	endfunction

	task automatic add_op(input logic rd, input logic wr, input cache_pkg::addr_t a,
		input cache_pkg::word_t wd, input logic hit, input string name);
		op_t op;
		op.rd = rd;
		op.wr = wr;
		op.addr = a;
		op.wdata = wd;
		op.exp_hit = hit;
		ops.push_back(op);
		names.push_back(name);
	endtask

	task automatic build_table;
		// cold misses read zero
		add_op(1, 0, make_addr(1, 8'h10, 0), 16'h0000, 0, "cold_rd_a");
		add_op(1, 0, make_addr(2, 8'h11, 2), 16'h0000, 0, "cold_rd_b");
		add_op(1, 0, make_addr(1, 8'h10, 4), 16'h0000, 1, "cold_line_hit");
		// write miss, then the rest of the line
		add_op(0, 1, make_addr(3, 8'h20, 2), 16'ha5a5, 0, "wr_miss");
		add_op(1, 0, make_addr(3, 8'h20, 2), 16'h0000, 1, "rd_after_wr");
		add_op(1, 0, make_addr(3, 8'h20, 0), 16'h0000, 1, "rd_word0");
		add_op(1, 0, make_addr(3, 8'h20, 4), 16'h0000, 1, "rd_word4");
		add_op(1, 0, make_addr(3, 8'h20, 6), 16'h0000, 1, "rd_word6");
		// two ways of one set, then victim eviction
		add_op(1, 0, make_addr(4, 8'h30, 0), 16'h0000, 0, "fill_way0");
		add_op(1, 0, make_addr(5, 8'h30, 0), 16'h0000, 0, "fill_way1");
		add_op(1, 0, make_addr(4, 8'h30, 0), 16'h0000, 1, "hit_way0");
		add_op(1, 0, make_addr(5, 8'h30, 6), 16'h0000, 1, "hit_way1");
		add_op(1, 0, make_addr(6, 8'h30, 0), 16'h0000, 0, "evict_victim");
		add_op(1, 0, make_addr(5, 8'h30, 0), 16'h0000, 0, "evicted_miss");
		// both ways dirty, so the evictions write back
		add_op(0, 1, make_addr(7, 8'h40, 4), 16'h1234, 0, "dirty_fill");
		add_op(1, 0, make_addr(8, 8'h40, 0), 16'h0000, 0, "other_fill");
		add_op(0, 1, make_addr(8, 8'h40, 2), 16'h5678, 1, "other_wr_hit");
		add_op(1, 0, make_addr(9, 8'h40, 0), 16'h0000, 0, "dirty_evict");
		add_op(1, 0, make_addr(8, 8'h40, 2), 16'h0000, 0, "evicted_rd");
		add_op(1, 0, make_addr(7, 8'h40, 4), 16'h0000, 0, "evicted_rd_b");
		// write hit stays in the cache
		add_op(0, 1, make_addr(3, 8'h20, 6), 16'hbeef, 1, "wr_hit");
		add_op(1, 0, make_addr(3, 8'h20, 6), 16'h0000, 1, "rd_hit_new");
		add_op(1, 0, make_addr(3, 8'h20, 2), 16'h0000, 1, "rd_hit_old");
	endtask

	// hit way, else empty way 0 then 1, else victim
	task automatic predict(input cache_pkg::addr_t a, output logic hit, output logic way,
		output int lat);
		cache_pkg::index_t idx;
		cache_pkg::tag_t tg;
		idx = a[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
		tg = a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
		hit = 1'b1;
		if (m_valid[0][idx] && m_tag[0][idx] == tg)
			way = 1'b0;
		else if (m_valid[1][idx] && m_tag[1][idx] == tg)
			way = 1'b1;
		else
		begin
			hit = 1'b0;
			if (!m_valid[0][idx])
				way = 1'b0;
			else if (!m_valid[1][idx])
				way = 1'b1;
			else
				way = m_victim;
		end
		if (hit)
			lat = 0;
		else if (m_valid[way][idx] && m_dirty[way][idx])
			lat = FILL_CYCLES + WB_CYCLES;
		else
			lat = FILL_CYCLES;
	endtask

	task automatic commit(input op_t op, input logic hit, input logic way);
		cache_pkg::index_t idx;
		idx = op.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
		m_valid[way][idx] = 1'b1;
		m_tag[way][idx] = op.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
		m_dirty[way][idx] = hit ? (m_dirty[way][idx] | op.wr) : op.wr;
		if (!hit)
			m_victim = ~m_victim;
		if (op.wr)
			shadow[op.addr[`CACHE_ADDR_W-1:1]] = op.wdata;
	endtask

	// called 5 ns after a rising edge, returns the same way
	task automatic run_op(input op_t op, input string name, input logic use_table);
		logic exp_hit;
		logic way;
		int exp_lat;
		int lat;
		logic got;
		cache_pkg::word_t exp_data;
		predict(op.addr, exp_hit, way, exp_lat);
		exp_data = shadow[op.addr[`CACHE_ADDR_W-1:1]];
		if (use_table && op.exp_hit != exp_hit)
		begin
			$display("%s: operation table and tag model disagree on the hit", name);
			errors++;
		end
		req.rd = op.rd;
		req.wr = op.wr;
		req.addr = op.addr;
		req.wdata = op.wdata;
		got = 1'b0;
		lat = 0;
		@(negedge clk);
		// hits never touch memory
		if (exp_hit && (u_dut.mem_req.rd || u_dut.mem_req.wr))
		begin
			$display("%s: memory accessed during a hit", name);
			errors++;
		end
		while (!got)
		begin
			if (done)
				got = 1'b1;
			else
			begin
				// system held off until the fill ends
				if (stall !== 1'b1)
				begin
					$display("ERR %s stall in cycle %0d expected 1 actual %b",
						name, lat, stall);
					errors++;
				end
				lat++;
				@(negedge clk);
			end
		end
		checks++;
		if (stall !== 1'b0)
		begin
			$display("ERR %s stall at done expected 0 actual %b", name, stall);
			errors++;
		end
		if (cache_hit !== exp_hit)
		begin
			$display("ERR %s hit expected %0b actual %0b", name, exp_hit, cache_hit);
			errors++;
		end
		if (lat != exp_lat)
		begin
			$display("ERR %s done cycle expected %0d actual %0d", name, exp_lat, lat);
			errors++;
		end
		if (op.rd && rdata !== exp_data)
		begin
			$display("ERR %s rdata expected %h actual %h", name, exp_data, rdata);
			errors++;
		end
		commit(op, exp_hit, way);
		@(posedge clk);
		#5;
	endtask

	initial
	begin
		op_t op;
		clk = 1'b0;
		rst = 1'b1;
		req = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		m_victim = 1'b0;
		for (int w = 0; w < 2; w++)
			for (int s = 0; s < `CACHE_SETS; s++)
			begin
				m_valid[w][s] = 1'b0;
				m_dirty[w][s] = 1'b0;
				m_tag[w][s] = '0;
			end
		foreach (shadow[i])
			shadow[i] = '0;
		build_table();
		max_cycles = (ops.size() + RAND_OPS) * 12 + 20;

		repeat (2) @(posedge clk);
		#5;
		rst = 1'b0;
		@(negedge clk);
		// quiet state out of reset
		if (done || cache_hit || stall || u_dut.mem_req.rd || u_dut.mem_req.wr
			|| u_dut.way_we_0 || u_dut.way_we_1
			|| u_dut.u_ctrl.state_q != cache_pkg::idle || u_dut.u_ctrl.victim_q)
		begin
			$display("after reset the controller is not idle and quiet");
			errors++;
		end
		@(posedge clk);
		#5;

		for (int i = 0; i < ops.size(); i++)
			run_op(ops[i], names[i], 1'b1);

		// random phase on two sets and four tags
		seed = 32'h749b04b2;
		for (int i = 0; i < RAND_OPS; i++)
		begin
			seed = lcg_next(seed);
			op.wr = seed[31];
			op.rd = ~seed[31];
			op.addr = make_addr(seed[25:24], 8'h50 + seed[22], {seed[19:18], 1'b0});
			seed = lcg_next(seed);
			op.wdata = seed[31:16];
			op.exp_hit = 1'b0;
			run_op(op, $sformatf("rand_%0d", i), 1'b0);
		end
		req = '0;

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+include
source/cache_pkg.sv
source/cache_way.sv
source/cache_controller.sv
source/bank_memory.sv
source/cache_top.sv
testbench/cache_assert.sv
testbench/cache_tb.sv
